/* verilog/dnc_dim_pkg.sv */
// DNC memory dimensions
package dnc_dim_pkg;

  ////////////////////
  // Word format

  // Signed Q8.8 fixed point
  localparam int INT_BITS  = 8;
  localparam int FRAC_BITS = 8;
  localparam int DATA_SIZE = INT_BITS + FRAC_BITS;

  ////////////////////
  // Memory geometry

  // Number of read heads (R)
  localparam int READ_HEADS = 2;
  // Elements per key (W)
  localparam int WORD_SIZE  = 4;

  ////////////////////
  // Index widths

  // Holds R+1 values, write strength rides on head R
  localparam int HEAD_BITS = 2;
  // Element index 0 .. W-1
  localparam int ELEM_BITS = 2;

endpackage

/* verilog/dnc_frame_pkg.sv */
// DNC interface frame layout
package dnc_frame_pkg;

  import dnc_dim_pkg::*;

  ////////////////////
  // Field codes

  localparam logic [1:0] SEG_READ_KEYS = 2'd0;
  localparam logic [1:0] SEG_READ_STR  = 2'd1;
  localparam logic [1:0] SEG_WRITE_KEY = 2'd2;
  localparam logic [1:0] SEG_WRITE_STR = 2'd3;

  ////////////////////
  // Field offsets

  // Word counter covers a whole frame
  localparam int WORD_CNT_BITS = 4;

  // Read keys start at word 0, R*W words
  localparam logic [WORD_CNT_BITS-1:0] OFS_READ_STR  = WORD_CNT_BITS'(READ_HEADS * WORD_SIZE);
  localparam logic [WORD_CNT_BITS-1:0] OFS_WRITE_KEY = OFS_READ_STR + WORD_CNT_BITS'(READ_HEADS);
  localparam logic [WORD_CNT_BITS-1:0] OFS_WRITE_STR = OFS_WRITE_KEY + WORD_CNT_BITS'(WORD_SIZE);
  // One write strength closes the frame
  localparam logic [WORD_CNT_BITS-1:0] FRAME_WORDS   = OFS_WRITE_STR + 1'b1;

  ////////////////////
  // Fixed-point constants

  // 1.0 in Q8.8
  localparam logic [DATA_SIZE-1:0] FIXED_ONE =
    {{(DATA_SIZE-FRAC_BITS-1){1'b0}}, 1'b1, {FRAC_BITS{1'b0}}};
  // Largest positive word
  localparam logic [DATA_SIZE-1:0] FIXED_MAX = {1'b0, {(DATA_SIZE-1){1'b1}}};

endpackage

/* verilog/dnc_interface_parser.sv */
// Interface frame sequencer
`timescale 1ns/100ps

module dnc_interface_parser
  import dnc_dim_pkg::*;
  import dnc_frame_pkg::*;
(
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  // Frame word input
  input  logic                 in_valid,
  output logic                 in_ready,
  input  logic [DATA_SIZE-1:0] in_data,
  // Per-field valid
  output logic                 rk_in_valid,
  output logic                 wk_in_valid,
  output logic                 st_in_valid,
  // Per-field ready
  input  logic                 rk_in_ready,
  input  logic                 wk_in_ready,
  input  logic                 st_in_ready,
  output logic [DATA_SIZE-1:0] field_data,
  output logic                 busy,
  output logic                 frame_done
);

  // FSM state, 0 idle and 1 active
  logic                     active;
  logic [WORD_CNT_BITS-1:0] word_cnt;
  logic [1:0]               seg;
  logic                     sel_ready;
  logic                     in_fire;
  logic                     last_word;

  ////////////////////
  // Field decode

  // Current field from word position
  always_comb begin
    if (word_cnt < OFS_READ_STR) begin
      seg = SEG_READ_KEYS;
    end else if (word_cnt < OFS_WRITE_KEY) begin
      seg = SEG_READ_STR;
    end else if (word_cnt < OFS_WRITE_STR) begin
      seg = SEG_WRITE_KEY;
    end else begin
      seg = SEG_WRITE_STR;
    end
  end

  // Steer valid out, ready back
  always_comb begin
    rk_in_valid = 1'b0;
    wk_in_valid = 1'b0;
    st_in_valid = 1'b0;
    sel_ready   = 1'b0;
    case (seg)
      SEG_READ_KEYS: begin
        rk_in_valid = active && in_valid;
        sel_ready   = rk_in_ready;
      end
      SEG_WRITE_KEY: begin
        wk_in_valid = active && in_valid;
        sel_ready   = wk_in_ready;
      end
      // Both strengths share one unit
      SEG_READ_STR, SEG_WRITE_STR: begin
        st_in_valid = active && in_valid;
        sel_ready   = st_in_ready;
      end
      default: sel_ready = 1'b0;
    endcase
  end

  // No acceptance outside a frame
  assign in_ready   = active && sel_ready;
  assign field_data = in_data;
  assign in_fire    = in_valid && in_ready;
  assign last_word  = (word_cnt == FRAME_WORDS - 1'b1);
  assign busy       = active;

  ////////////////////
  // Frame control

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      active     <= 1'b0;
      word_cnt   <= '0;
      frame_done <= 1'b0;
    end else begin
      frame_done <= 1'b0;
      if (!active) begin
        // START only seen while idle
        if (START) begin
          active   <= 1'b1;
          word_cnt <= '0;
        end
      end else if (in_fire) begin
        if (last_word) begin
          active     <= 1'b0;
          word_cnt   <= '0;
          frame_done <= 1'b1;
        end else begin
          word_cnt <= word_cnt + 1'b1;
        end
      end
    end
  end

endmodule

/* verilog/dnc_key_stream.sv */
// Key element indexer
`timescale 1ns/100ps

module dnc_key_stream
  import dnc_dim_pkg::*;
#(
  // Heads per frame, R for read keys and 1 for the write key
  parameter int HEADS = READ_HEADS
) (
  input  logic                 CLK,
  input  logic                 RST,
  // Element input
  input  logic                 in_valid,
  output logic                 in_ready,
  input  logic [DATA_SIZE-1:0] in_data,
  // Tagged element output
  output logic                 out_valid,
  input  logic                 out_ready,
  output logic [DATA_SIZE-1:0] out_data,
  output logic [HEAD_BITS-1:0] out_head,
  output logic [ELEM_BITS-1:0] out_elem,
  output logic                 out_last
);

  logic [HEAD_BITS-1:0] head_idx;
  logic [ELEM_BITS-1:0] elem_idx;
  logic                 in_fire;
  logic                 elem_wrap;
  logic                 head_wrap;

  // Free slot or draining this cycle
  assign in_ready  = !out_valid || out_ready;
  assign in_fire   = in_valid && in_ready;
  assign elem_wrap = (elem_idx == ELEM_BITS'(WORD_SIZE - 1));
  assign head_wrap = (head_idx == HEAD_BITS'(HEADS - 1));

  ////////////////////
  // Index counters

  // k(i;k) walks k fastest, then i
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      head_idx <= '0;
      elem_idx <= '0;
    end else if (in_fire) begin
      if (elem_wrap) begin
        elem_idx <= '0;
        // Last head wraps back for next frame
        head_idx <= head_wrap ? '0 : head_idx + 1'b1;
      end else begin
        elem_idx <= elem_idx + 1'b1;
      end
    end
  end

  ////////////////////
  // Output register

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  // Element copied unchanged with its tags
  always_ff @(posedge CLK) begin
    if (in_fire) begin
      out_data <= in_data;
      out_head <= head_idx;
      out_elem <= elem_idx;
      out_last <= elem_wrap && head_wrap;
    end
  end

endmodule

/* verilog/dnc_strength_unit.sv */
// Oneplus strength stage
`timescale 1ns/100ps

module dnc_strength_unit
  import dnc_dim_pkg::*;
  import dnc_frame_pkg::*;
(
  input  logic                 CLK,
  input  logic                 RST,
  // Raw strength input
  input  logic                 in_valid,
  output logic                 in_ready,
  input  logic [DATA_SIZE-1:0] in_data,
  // Conditioned strength output
  output logic                 out_valid,
  input  logic                 out_ready,
  output logic [DATA_SIZE-1:0] out_data,
  output logic [HEAD_BITS-1:0] out_head
);

  logic [HEAD_BITS-1:0] head_idx;
  logic                 in_fire;
  logic                 head_wrap;
  logic [DATA_SIZE-1:0] pos_part;
  logic [DATA_SIZE:0]   sum;
  logic [DATA_SIZE-1:0] oneplus;

  assign in_ready  = !out_valid || out_ready;
  assign in_fire   = in_valid && in_ready;
  // Head R is the write strength
  assign head_wrap = (head_idx == HEAD_BITS'(READ_HEADS));

  ////////////////////
  // Oneplus datapath

  // Negative inputs clamp to zero
  assign pos_part = in_data[DATA_SIZE-1] ? '0 : in_data;
  // One guard bit, cannot wrap
  assign sum      = {1'b0, FIXED_ONE} + {1'b0, pos_part};
  assign oneplus  = (sum > {1'b0, FIXED_MAX}) ? FIXED_MAX : sum[DATA_SIZE-1:0];

  ////////////////////
  // Head counter and output

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      head_idx  <= '0;
      out_valid <= 1'b0;
    end else begin
      if (in_fire) begin
        head_idx <= head_wrap ? '0 : head_idx + 1'b1;
      end
      if (in_ready) begin
        out_valid <= in_valid;
      end
    end
  end

  // Result and head tag
  always_ff @(posedge CLK) begin
    if (in_fire) begin
      out_data <= oneplus;
      out_head <= head_idx;
    end
  end

endmodule

/* verilog/dnc_interface.sv */
// DNC interface vector front end
`timescale 1ns/100ps

module dnc_interface
  import dnc_dim_pkg::*;
(
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  // Frame input
  input  logic                 in_valid,
  output logic                 in_ready,
  input  logic [DATA_SIZE-1:0] in_data,
  // Read keys
  output logic                 rk_valid,
  input  logic                 rk_ready,
  output logic [DATA_SIZE-1:0] rk_data,
  output logic [HEAD_BITS-1:0] rk_head,
  output logic [ELEM_BITS-1:0] rk_elem,
  output logic                 rk_last,
  // Write key
  output logic                 wk_valid,
  input  logic                 wk_ready,
  output logic [DATA_SIZE-1:0] wk_data,
  output logic [ELEM_BITS-1:0] wk_elem,
  output logic                 wk_last,
  // Read and write strengths
  output logic                 st_valid,
  input  logic                 st_ready,
  output logic [DATA_SIZE-1:0] st_data,
  output logic [HEAD_BITS-1:0] st_head,
  // Frame status
  output logic                 busy,
  output logic                 frame_done
);

  // Parser to field blocks
  logic                 rk_in_valid;
  logic                 wk_in_valid;
  logic                 st_in_valid;
  logic                 rk_in_ready;
  logic                 wk_in_ready;
  logic                 st_in_ready;
  logic [DATA_SIZE-1:0] field_data;

  ////////////////////
  // Frame sequencer

  dnc_interface_parser u_parser (
    .CLK         (CLK),
    .RST         (RST),
    .START       (START),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_data     (in_data),
    .rk_in_valid (rk_in_valid),
    .wk_in_valid (wk_in_valid),
    .st_in_valid (st_in_valid),
    .rk_in_ready (rk_in_ready),
    .wk_in_ready (wk_in_ready),
    .st_in_ready (st_in_ready),
    .field_data  (field_data),
    .busy        (busy),
    .frame_done  (frame_done)
  );

  ////////////////////
  // Field blocks

  // R heads of W elements
  dnc_key_stream #(
    .HEADS (READ_HEADS)
  ) u_read_keys (
    .CLK       (CLK),
    .RST       (RST),
    .in_valid  (rk_in_valid),
    .in_ready  (rk_in_ready),
    .in_data   (field_data),
    .out_valid (rk_valid),
    .out_ready (rk_ready),
    .out_data  (rk_data),
    .out_head  (rk_head),
    .out_elem  (rk_elem),
    .out_last  (rk_last)
  );

  // Single head, head tag unused
  dnc_key_stream #(
    .HEADS (1)
  ) u_write_key (
    .CLK       (CLK),
    .RST       (RST),
    .in_valid  (wk_in_valid),
    .in_ready  (wk_in_ready),
    .in_data   (field_data),
    .out_valid (wk_valid),
    .out_ready (wk_ready),
    .out_data  (wk_data),
    .out_head  (),
    .out_elem  (wk_elem),
    .out_last  (wk_last)
  );

  dnc_strength_unit u_strength (
    .CLK       (CLK),
    .RST       (RST),
    .in_valid  (st_in_valid),
    .in_ready  (st_in_ready),
    .in_data   (field_data),
    .out_valid (st_valid),
    .out_ready (st_ready),
    .out_data  (st_data),
    .out_head  (st_head)
  );

endmodule

/* test/tb_clock_gen.sv */
// Testbench clock and reset
`timescale 1ns/100ps

module tb_clock_gen (
  output logic CLK,
  output logic RST
);

  // 8 ns period
  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  // Reset over the first four cycles, released on a falling edge
  initial begin
    RST = 1'b1;
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
  end

endmodule

/* test/dnc_interface_chk.sv */
// Interface stream checks
`timescale 1ns/100ps

module dnc_interface_chk
  import dnc_dim_pkg::*;
(
  input logic                 CLK,
  input logic                 RST,
  input logic                 in_ready,
  input logic                 busy,
  input logic                 frame_done,
  input logic                 rk_valid,
  input logic                 rk_ready,
  input logic [DATA_SIZE-1:0] rk_data,
  input logic [HEAD_BITS-1:0] rk_head,
  input logic [ELEM_BITS-1:0] rk_elem,
  input logic                 rk_last,
  input logic                 wk_valid,
  input logic                 wk_ready,
  input logic [DATA_SIZE-1:0] wk_data,
  input logic                 st_valid,
  input logic                 st_ready,
  input logic [DATA_SIZE-1:0] st_data
);

  ////////////////////
  // Stall stability

  // Stalled output holds valid and data
  a_rk_hold: assert property (@(posedge CLK) disable iff (RST)
    rk_valid && !rk_ready |=> rk_valid && $stable(rk_data))
    else $error("read key stream changed while stalled");

  a_wk_hold: assert property (@(posedge CLK) disable iff (RST)
    wk_valid && !wk_ready |=> wk_valid && $stable(wk_data))
    else $error("write key stream changed while stalled");

  a_st_hold: assert property (@(posedge CLK) disable iff (RST)
    st_valid && !st_ready |=> st_valid && $stable(st_data))
    else $error("strength stream changed while stalled");

  ////////////////////
  // Frame markers

  // Last read key only on final head, final element
  a_rk_last: assert property (@(posedge CLK) disable iff (RST)
    rk_valid && rk_last |->
      rk_head == HEAD_BITS'(READ_HEADS - 1) && rk_elem == ELEM_BITS'(WORD_SIZE - 1))
    else $error("rk_last raised away from the final element");

  // Single-cycle pulse
  a_done_pulse: assert property (@(posedge CLK) disable iff (RST)
    frame_done |=> !frame_done)
    else $error("frame_done held longer than one cycle");

  // Nothing accepted outside a frame
  a_idle_ready: assert property (@(posedge CLK) disable iff (RST)
    !busy |-> !in_ready)
    else $error("in_ready high while no frame is open");

endmodule

/* test/tb_dnc_interface.sv */
// DNC interface testbench
`timescale 1ns/100ps

module tb_dnc_interface
  import dnc_dim_pkg::*;
  import dnc_frame_pkg::*;
();

  localparam int FRAMES         = 20;
  localparam int FRAME_LEN      = int'(FRAME_WORDS);
  // Read keys lead the frame
  localparam int RK_WORDS       = READ_HEADS * WORD_SIZE;
  localparam int TIMEOUT_CYCLES = FRAMES * FRAME_LEN * 8 + 200;

  logic                 CLK;
  logic                 RST;
  logic                 START;
  logic                 in_valid;
  logic                 in_ready;
  logic [DATA_SIZE-1:0] in_data;
  logic                 rk_valid;
  logic                 rk_ready;
  logic [DATA_SIZE-1:0] rk_data;
  logic [HEAD_BITS-1:0] rk_head;
  logic [ELEM_BITS-1:0] rk_elem;
  logic                 rk_last;
  logic                 wk_valid;
  logic                 wk_ready;
  logic [DATA_SIZE-1:0] wk_data;
  logic [ELEM_BITS-1:0] wk_elem;
  logic                 wk_last;
  logic                 st_valid;
  logic                 st_ready;
  logic [DATA_SIZE-1:0] st_data;
  logic [HEAD_BITS-1:0] st_head;
  logic                 busy;
  logic                 frame_done;

  // Model queues packed as {last, head, elem, data} and the like
  logic [DATA_SIZE+HEAD_BITS+ELEM_BITS:0] rk_q[$];
  logic [DATA_SIZE+ELEM_BITS:0]           wk_q[$];
  logic [DATA_SIZE+HEAD_BITS-1:0]         st_q[$];

  int in_pos;
  bit done_due;
  bit busy_exp;
  int frames_seen;
  int cycles;
  int value_errors;
  int other_errors;

  tb_clock_gen u_clk (
    .CLK (CLK),
    .RST (RST)
  );

  dnc_interface DUT (
    .CLK        (CLK),
    .RST        (RST),
    .START      (START),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_data    (in_data),
    .rk_valid   (rk_valid),
    .rk_ready   (rk_ready),
    .rk_data    (rk_data),
    .rk_head    (rk_head),
    .rk_elem    (rk_elem),
    .rk_last    (rk_last),
    .wk_valid   (wk_valid),
    .wk_ready   (wk_ready),
    .wk_data    (wk_data),
    .wk_elem    (wk_elem),
    .wk_last    (wk_last),
    .st_valid   (st_valid),
    .st_ready   (st_ready),
    .st_data    (st_data),
    .st_head    (st_head),
    .busy       (busy),
    .frame_done (frame_done)
  );

  bind dnc_interface dnc_interface_chk u_chk (.*);

  ////////////////////
  // Reference model

  // One plus positive part clipped to largest word
  function automatic logic [DATA_SIZE-1:0] oneplus_ref(input logic signed [DATA_SIZE-1:0] x);
    int v;
    v = int'(FIXED_ONE);
    if (x > 0) begin
      v = v + int'(x);
    end
    if (v > int'(FIXED_MAX)) begin
      v = int'(FIXED_MAX);
    end
    return DATA_SIZE'(v);
  endfunction

  // Zero, saturating and negative corner values mixed into random words
  function automatic logic [DATA_SIZE-1:0] pick_word();
    logic [DATA_SIZE-1:0] w;
    case ($urandom_range(0, 7))
      0:       w = '0;
      1:       w = 16'h7FFF;
      2:       w = 16'h7F00;
      3:       w = 16'hFFFF;
      default: w = DATA_SIZE'($urandom());
    endcase
    return w;
  endfunction

  // Route an accepted word by its position in the frame
  task automatic record_word(input logic [DATA_SIZE-1:0] w);
    if (in_pos < RK_WORDS) begin
      rk_q.push_back({in_pos == RK_WORDS - 1, HEAD_BITS'(in_pos / WORD_SIZE),
                      ELEM_BITS'(in_pos % WORD_SIZE), w});
    end else if (in_pos < RK_WORDS + READ_HEADS) begin
      st_q.push_back({HEAD_BITS'(in_pos - RK_WORDS), oneplus_ref(w)});
    end else if (in_pos < FRAME_LEN - 1) begin
      wk_q.push_back({in_pos == FRAME_LEN - 2,
                      ELEM_BITS'(in_pos - RK_WORDS - READ_HEADS), w});
    end else begin
      // Write strength rides on head R
      st_q.push_back({HEAD_BITS'(READ_HEADS), oneplus_ref(w)});
    end
    if (in_pos == FRAME_LEN - 1) begin
      in_pos   = 0;
      done_due = 1'b1;
      busy_exp = 1'b0;
    end else begin
      in_pos++;
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act == exp) else begin
      value_errors++;
      $display("[ERROR] %s expected %0h got %0h", name, exp, act);
    end
  endtask

  task automatic check_read_key();
    logic [DATA_SIZE+HEAD_BITS+ELEM_BITS:0] exp;
    assert (rk_q.size() != 0) else begin
      other_errors++;
      $display("Read key came out with nothing expected");
    end
    if (rk_q.size() != 0) begin
      exp = rk_q.pop_front();
      check_value("rk_data", exp[DATA_SIZE-1:0], rk_data);
      check_value("rk_elem", exp[DATA_SIZE+:ELEM_BITS], rk_elem);
      check_value("rk_head", exp[DATA_SIZE+ELEM_BITS+:HEAD_BITS], rk_head);
      check_value("rk_last", exp[DATA_SIZE+ELEM_BITS+HEAD_BITS], rk_last);
    end
  endtask

  task automatic check_write_key();
    logic [DATA_SIZE+ELEM_BITS:0] exp;
    assert (wk_q.size() != 0) else begin
      other_errors++;
      $display("Write key came out with nothing expected");
    end
    if (wk_q.size() != 0) begin
      exp = wk_q.pop_front();
      check_value("wk_data", exp[DATA_SIZE-1:0], wk_data);
      check_value("wk_elem", exp[DATA_SIZE+:ELEM_BITS], wk_elem);
      check_value("wk_last", exp[DATA_SIZE+ELEM_BITS], wk_last);
    end
  endtask

  task automatic check_strength();
    logic [DATA_SIZE+HEAD_BITS-1:0] exp;
    assert (st_q.size() != 0) else begin
      other_errors++;
      $display("Strength came out with nothing expected");
    end
    if (st_q.size() != 0) begin
      exp = st_q.pop_front();
      check_value("st_data", exp[DATA_SIZE-1:0], st_data);
      check_value("st_head", exp[DATA_SIZE+:HEAD_BITS], st_head);
    end
  endtask

  ////////////////////
  // Monitor

  // Samples transfers at the rising edge before registers move
  always @(posedge CLK) begin
    cycles++;
    if (!RST) begin
      // frame_done one cycle after the closing word
      assert (frame_done == done_due) else begin
        other_errors++;
        $display("frame_done missing or misplaced at cycle %0d", cycles);
      end
      if (frame_done) begin
        frames_seen++;
      end
      done_due = 1'b0;
      // busy opens on START and closes after the last word
      check_value("busy", busy_exp, busy);
      if (START && !busy_exp) begin
        busy_exp = 1'b1;
      end
      if (in_valid && in_ready) begin
        assert (busy) else begin
          other_errors++;
          $display("Input word consumed with no frame open");
        end
        record_word(in_data);
      end
      if (rk_valid && rk_ready) begin
        check_read_key();
      end
      if (wk_valid && wk_ready) begin
        check_write_key();
      end
      if (st_valid && st_ready) begin
        check_strength();
      end
    end
  end

  ////////////////////
  // Stimulus

  // Random back-pressure with ready high three times in four
  always @(negedge CLK) begin
    if (!RST) begin
      rk_ready = ($urandom_range(0, 3) != 0);
      wk_ready = ($urandom_range(0, 3) != 0);
      st_ready = ($urandom_range(0, 3) != 0);
    end
  end

  // Hold one word until the parser takes it
  task automatic send_word(input logic [DATA_SIZE-1:0] w, input bit gap);
    bit taken;
    if (gap) begin
      in_valid = 1'b0;
      repeat ($urandom_range(0, 2)) @(negedge CLK);
    end
    in_valid = 1'b1;
    in_data  = w;
    taken    = 1'b0;
    while (!taken) begin
      @(posedge CLK);
      taken = in_ready;
      @(negedge CLK);
    end
  endtask

  task automatic run_frame();
    int i;
    // First word waits at the input while idle
    in_valid = 1'b1;
    in_data  = pick_word();
    repeat ($urandom_range(1, 3)) @(negedge CLK);
    START = 1'b1;
    @(negedge CLK);
    START = 1'b0;
    send_word(in_data, 1'b0);
    for (i = 1; i < FRAME_LEN; i++) begin
      send_word(pick_word(), bit'($urandom_range(0, 1)));
    end
  endtask

  initial begin
    int frame;
    START    = 1'b0;
    in_valid = 1'b0;
    in_data  = '0;
    rk_ready = 1'b0;
    wk_ready = 1'b0;
    st_ready = 1'b0;
    void'($urandom(32'hd621));
    @(negedge CLK);
    while (RST) begin
      @(negedge CLK);
    end
    for (frame = 0; frame < FRAMES; frame++) begin
      run_frame();
    end
    in_valid = 1'b0;
    // Drain whatever is still in the field blocks
    while (rk_q.size() != 0 || wk_q.size() != 0 || st_q.size() != 0) begin
      @(negedge CLK);
    end
    repeat (2) @(negedge CLK);
    assert (frames_seen == FRAMES) else begin
      other_errors++;
      $display("Saw %0d frame_done pulses for %0d frames", frames_seen, FRAMES);
    end
    $display("Errors: %0d value, %0d protocol", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Watchdog on the cycle count
  initial begin
    wait (cycles >= TIMEOUT_CYCLES);
    $display("Timeout after %0d cycles, frames did not complete", cycles);
    $display(">>> FAIL");
    $finish;
  end

endmodule

/* sim.f */
verilog/dnc_dim_pkg.sv
verilog/dnc_frame_pkg.sv
verilog/dnc_interface_parser.sv
verilog/dnc_key_stream.sv
verilog/dnc_strength_unit.sv
verilog/dnc_interface.sv
test/tb_clock_gen.sv
test/dnc_interface_chk.sv
test/tb_dnc_interface.sv

/* run.sh */
#!/bin/sh
# Build and run the DNC interface testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module tb_dnc_interface -f sim.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

./obj_dir/Vtb_dnc_interface > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q ">>> FAIL" sim.log; then
  echo "Test failed"
  exit 1
fi

echo "Test passed"
exit 0
